//--- hdl/branch_settings.svh
`ifndef BRANCH_SETTINGS_SVH
`define BRANCH_SETTINGS_SVH

// Datapath widths
`define BR_XLEN   32
`define BR_OFFW   16
`define BR_CNTW   32
`define BR_AXI_AW 4

// Statistics register byte offsets
`define BR_REG_CTRL     4'h0
`define BR_REG_RESOLVED 4'h4
`define BR_REG_TAKEN    4'h8

// Two-operand compares
`define BR_OP_BEQ  3'd0
`define BR_OP_BNE  3'd1
`define BR_OP_BLT  3'd2
`define BR_OP_BGT  3'd3
// Tests of rs against zero
`define BR_OP_BLEZ 3'd4
`define BR_OP_BGTZ 3'd5
`define BR_OP_BLTZ 3'd6
`define BR_OP_BGEZ 3'd7

`endif

//--- hdl/branchPkg.sv
`default_nettype none

`include "branch_settings.svh"

package branchPkg;

    // Register operand and program counter
    typedef logic [`BR_XLEN-1:0] word_t;
    typedef logic [`BR_XLEN-1:0] pc_t;

    // Word offset as it sits in the instruction, sign bit on top
    typedef logic [`BR_OFFW-1:0] offset_t;

    typedef logic [2:0] brOp_t;

    // Statistics counters
    typedef logic [`BR_CNTW-1:0] count_t;

    typedef logic [`BR_AXI_AW-1:0] axiAddr_t;

    // Slave machine of the statistics block
    typedef enum logic [1:0] {
        stIdle,
        stWriteResp,
        stReadData
    } axiState_t;

endpackage

`default_nettype wire

//--- hdl/branchComparator.sv
`timescale 1ns/1ps
`default_nettype none

module branchComparator
    import branchPkg::*;
(
    input  word_t a,
    input  word_t b,
    output logic  eq,
    output logic  lt,
    output logic  gt,
    output logic  zero,
    output logic  ltz,
    output logic  gtz
);

    //////////////////////////////
    // Operand against operand
    //////////////////////////////

    // One signed compare covers all sign combinations
    always_comb begin
        eq = 1'b0;
        lt = 1'b0;
        gt = 1'b0;
        if ($signed(a) < $signed(b)) begin
            lt = 1'b1;
        end else if ($signed(a) > $signed(b)) begin
            gt = 1'b1;
        end else begin
            eq = 1'b1;
        end
    end

    //////////////////////////////
    // First operand against zero
    //////////////////////////////

    always_comb begin
        zero = 1'b0;
        ltz  = 1'b0;
        gtz  = 1'b0;
        if ($signed(a) < 0) begin
            ltz = 1'b1;
        end else if (a == '0) begin
            zero = 1'b1;
        end else begin
            gtz = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/branchResolve.sv
`timescale 1ns/1ps
`default_nettype none

`include "branch_settings.svh"

module branchResolve
    import branchPkg::*;
(
    input  logic    clk,
    input  logic    arstN,
    input  logic    issueValid,
    input  brOp_t   issueOp,
    input  word_t   rs,
    input  word_t   rt,
    input  pc_t     pc,
    input  offset_t offset,
    output logic    resValid,
    output logic    taken,
    output pc_t     nextPc
);

    logic flagEq;
    logic flagLt;
    logic flagGt;
    logic flagZero;
    logic flagLtz;
    logic flagGtz;
    logic cond;
    pc_t  pcPlus4;
    pc_t  branchOff;
    pc_t  target;

    branchComparator uCmp (
        .a    (rs),
        .b    (rt),
        .eq   (flagEq),
        .lt   (flagLt),
        .gt   (flagGt),
        .zero (flagZero),
        .ltz  (flagLtz),
        .gtz  (flagGtz)
    );

    // Opcode to branch condition
    always_comb begin
        case (issueOp)
            `BR_OP_BEQ:  cond = flagEq;
            `BR_OP_BNE:  cond = !flagEq;
            `BR_OP_BLT:  cond = flagLt;
            `BR_OP_BGT:  cond = flagGt;
            `BR_OP_BLEZ: cond = flagLtz || flagZero;
            `BR_OP_BGTZ: cond = flagGtz;
            `BR_OP_BLTZ: cond = flagLtz;
            `BR_OP_BGEZ: cond = !flagLtz;
            default:     cond = 1'b0;
        endcase
    end

    // Sign-extended word offset, wraps at the top of the address space
    assign pcPlus4   = pc + pc_t'(4);
    assign branchOff = {{(`BR_XLEN - `BR_OFFW - 2){offset[`BR_OFFW-1]}}, offset, 2'b00};
    assign target    = pcPlus4 + branchOff;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            resValid <= 1'b0;
            taken    <= 1'b0;
            nextPc   <= '0;
        end else begin
            resValid <= issueValid;
            // Result held through idle cycles
            if (issueValid) begin
                taken  <= cond;
                nextPc <= cond ? target : pcPlus4;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/branchStatsRegs.sv
`timescale 1ns/1ps
`default_nettype none

`include "branch_settings.svh"

module branchStatsRegs
    import branchPkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    input  logic       evValid,
    input  logic       evTaken,
    // Write address
    input  logic       awvalid,
    output logic       awready,
    input  axiAddr_t   awaddr,
    // Write data
    input  logic       wvalid,
    output logic       wready,
    input  word_t      wdata,
    // Write response
    output logic       bvalid,
    input  logic       bready,
    output logic [1:0] bresp,
    // Read address
    input  logic       arvalid,
    output logic       arready,
    input  axiAddr_t   araddr,
    // Read data
    output logic       rvalid,
    input  logic       rready,
    output word_t      rdata,
    output logic [1:0] rresp
);

    localparam logic [1:0] RespOkay = 2'b00;

    axiState_t state;
    axiState_t stateNext;
    logic      wrAccept;
    logic      rdAccept;
    logic      ctrlWrite;
    logic      clearCnt;
    logic      cntEnable;
    count_t    cntResolved;
    count_t    cntTaken;
    word_t     rdMux;

    //////////////////////////////
    // Slave handshake
    //////////////////////////////

    // Write wins a tie with a read
    assign wrAccept = (state == stIdle) && awvalid && wvalid;
    assign rdAccept = (state == stIdle) && arvalid && !wrAccept;

    assign awready = wrAccept;
    assign wready  = wrAccept;
    assign arready = rdAccept;

    assign bvalid = (state == stWriteResp);
    assign rvalid = (state == stReadData);
    assign bresp  = RespOkay;
    assign rresp  = RespOkay;

    always_comb begin
        stateNext = state;
        case (state)
            stIdle: begin
                if (wrAccept) begin
                    stateNext = stWriteResp;
                end else if (rdAccept) begin
                    stateNext = stReadData;
                end
            end
            stWriteResp: begin
                if (bready) begin
                    stateNext = stIdle;
                end
            end
            stReadData: begin
                if (rready) begin
                    stateNext = stIdle;
                end
            end
            default: stateNext = stIdle;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stIdle;
        end else begin
            state <= stateNext;
        end
    end

    //////////////////////////////
    // Control and counters
    //////////////////////////////

    // Counter offsets take no writes
    assign ctrlWrite = wrAccept && (awaddr == `BR_REG_CTRL);
    assign clearCnt  = ctrlWrite && wdata[1];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cntEnable <= 1'b0;
        end else if (ctrlWrite) begin
            cntEnable <= wdata[0];
        end
    end

    // Clear beats counting in the same cycle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cntResolved <= '0;
            cntTaken    <= '0;
        end else if (clearCnt) begin
            cntResolved <= '0;
            cntTaken    <= '0;
        end else if (cntEnable && evValid) begin
            cntResolved <= cntResolved + count_t'(1);
            if (evTaken) begin
                cntTaken <= cntTaken + count_t'(1);
            end
        end
    end

    //////////////////////////////
    // Read data
    //////////////////////////////

    // Clear bit always reads as zero
    always_comb begin
        case (araddr)
            `BR_REG_CTRL:     rdMux = {{(`BR_XLEN-1){1'b0}}, cntEnable};
            `BR_REG_RESOLVED: rdMux = cntResolved;
            `BR_REG_TAKEN:    rdMux = cntTaken;
            default:          rdMux = '0;
        endcase
    end

    // Captured at acceptance, held while rvalid waits
    always_ff @(posedge clk) begin
        if (rdAccept) begin
            rdata <= rdMux;
        end
    end

endmodule

`default_nettype wire

//--- hdl/branchUnitTop.sv
`timescale 1ns/1ps
`default_nettype none

module branchUnitTop
    import branchPkg::*;
(
    input  logic       clk,
    input  logic       arstN,
    // Issue
    input  logic       issueValid,
    input  brOp_t      issueOp,
    input  word_t      rs,
    input  word_t      rt,
    input  pc_t        pc,
    input  offset_t    offset,
    // Result
    output logic       resValid,
    output logic       taken,
    output pc_t        nextPc,
    // AXI4-Lite statistics port
    input  logic       awvalid,
    output logic       awready,
    input  axiAddr_t   awaddr,
    input  logic       wvalid,
    output logic       wready,
    input  word_t      wdata,
    output logic       bvalid,
    input  logic       bready,
    output logic [1:0] bresp,
    input  logic       arvalid,
    output logic       arready,
    input  axiAddr_t   araddr,
    output logic       rvalid,
    input  logic       rready,
    output word_t      rdata,
    output logic [1:0] rresp
);

    branchResolve uResolve (
        .clk        (clk),
        .arstN      (arstN),
        .issueValid (issueValid),
        .issueOp    (issueOp),
        .rs         (rs),
        .rt         (rt),
        .pc         (pc),
        .offset     (offset),
        .resValid   (resValid),
        .taken      (taken),
        .nextPc     (nextPc)
    );

    // Result port doubles as the event source
    branchStatsRegs uStats (
        .clk     (clk),
        .arstN   (arstN),
        .evValid (resValid),
        .evTaken (taken),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp)
    );

endmodule

`default_nettype wire

//--- tests/branchUnit_chk.sv
`timescale 1ns/1ps
`default_nettype none

module branchUnit_chk (
    input logic clk, arstN, issueValid, resValid,
    input logic awready, wready, arready,
    input logic bvalid, bready, rvalid, rready
);

    int failCount = 0;

    // Result port runs exactly one cycle behind the issue port
    resultTiming: assert property (@(posedge clk) disable iff (!arstN)
        resValid == $past(issueValid))
    else begin
        failCount++;
        $error("resValid does not follow issueValid by one cycle");
    end

    bvalidHeld: assert property (@(posedge clk) disable iff (!arstN)
        bvalid && !bready |=> bvalid)
    else begin
        failCount++;
        $error("bvalid dropped before bready");
    end

    rvalidHeld: assert property (@(posedge clk) disable iff (!arstN)
        rvalid && !rready |=> rvalid)
    else begin
        failCount++;
        $error("rvalid dropped before rready");
    end

    // Nothing handshakes while reset is held
    quietInReset: assert property (@(posedge clk)
        !arstN |-> !(resValid || awready || wready || arready || bvalid || rvalid))
    else begin
        failCount++;
        $error("handshake output high during reset");
    end

endmodule

bind branchUnitTop branchUnit_chk uChk (.*);

`default_nettype wire

//--- tests/branchUnit_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "branch_settings.svh"

module branchUnit_tb
    import branchPkg::*;
();

    localparam int AxiAccesses = 17;
    localparam int MaxVectors  = 64;

    // AXI OKAY response code
    localparam logic [1:0] RespOkay = 2'b00;

    logic       clk = 1'b0;
    logic       arstN, issueValid, resValid, taken;
    brOp_t      issueOp;
    word_t      rs, rt, wdata, rdata;
    pc_t        pc, nextPc;
    offset_t    offset;
    logic       awvalid, awready, wvalid, wready, bvalid, bready;
    logic       arvalid, arready, rvalid, rready;
    logic [1:0] bresp, rresp;
    axiAddr_t   awaddr, araddr;

    // Vectors from the data file
    string   vecName[MaxVectors];
    brOp_t   vecOp[MaxVectors];
    word_t   vecRs[MaxVectors], vecRt[MaxVectors];
    pc_t     vecPc[MaxVectors], vecNext[MaxVectors];
    offset_t vecOff[MaxVectors];
    logic    vecTaken[MaxVectors];
    int      nVec = 0;

    int mismatches = 0;
    int otherErrors = 0;
    bit vecLoaded = 0;
    // Vector on the issue port, and the one whose result is due
    int drvIdx = 0;
    int pendIdx = -1;

    branchUnitTop u_dut (.*);

    initial begin
        forever #2 clk = ~clk;
    end

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic checkBit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch %s: expected %0b, actual %0b", name, expected, actual);
        end
    endtask

    task automatic checkPc(string name, pc_t expected, pc_t actual);
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic checkCount(string name, count_t expected, count_t actual);
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic checkResp(string name, logic [1:0] expected, logic [1:0] actual);
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    //////////////////////////////
    // Drivers
    //////////////////////////////

    task automatic afterEdge();
        @(posedge clk);
        #1;
    endtask

    task automatic issueVector(int i);
        afterEdge();
        issueValid = 1'b1;
        issueOp    = vecOp[i];
        rs         = vecRs[i];
        rt         = vecRt[i];
        pc         = vecPc[i];
        offset     = vecOff[i];
        drvIdx     = i;
    endtask

    task automatic idleCycles(int n);
        repeat (n) begin
            afterEdge();
            issueValid = 1'b0;
        end
    endtask

    task automatic axiWrite(axiAddr_t addr, word_t data);
        afterEdge();
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = addr;
        wdata   = data;
        do @(negedge clk); while (!awready);
        checkBit("write wready", 1'b1, wready);
        afterEdge();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        // Master is slow to take the response
        repeat ($urandom_range(3, 0)) afterEdge();
        bready = 1'b1;
        do @(negedge clk); while (!bvalid);
        checkResp("write bresp", RespOkay, bresp);
        afterEdge();
        bready = 1'b0;
    endtask

    task automatic axiRead(axiAddr_t addr, output word_t data);
        afterEdge();
        arvalid = 1'b1;
        araddr  = addr;
        do @(negedge clk); while (!arready);
        afterEdge();
        arvalid = 1'b0;
        repeat ($urandom_range(3, 0)) afterEdge();
        rready = 1'b1;
        do @(negedge clk); while (!rvalid);
        data = rdata;
        checkResp("read rresp", RespOkay, rresp);
        afterEdge();
        rready = 1'b0;
    endtask

    task automatic readExpect(string name, axiAddr_t addr, count_t expected);
        word_t data;
        axiRead(addr, data);
        checkCount(name, expected, data);
    endtask

    task automatic reportCounts();
        $display("errors: %0d mismatches, %0d other, %0d assertion failures",
                 mismatches, otherErrors, u_dut.uChk.failCount);
    endtask

    // One result per issue, on the next cycle and never in idle cycles
    always @(negedge clk) begin
        if (pendIdx >= 0) begin
            checkBit({vecName[pendIdx], " resValid"}, 1'b1, resValid);
            checkBit({vecName[pendIdx], " taken"}, vecTaken[pendIdx], taken);
            checkPc({vecName[pendIdx], " nextPc"}, vecNext[pendIdx], nextPc);
        end else begin
            checkBit("idle resValid", 1'b0, resValid);
        end
        pendIdx = issueValid ? drvIdx : -1;
    end

    initial begin
        int limit;
        wait (vecLoaded);
        limit = 200 + 20 * 2 * nVec + 50 * AxiAccesses;
        repeat (limit) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", limit);
        otherErrors++;
        reportCounts();
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int    fd;
        int    nTaken;
        string line;

        void'($urandom(71451));
        {issueValid, issueOp, rs, rt, pc, offset} = '0;
        {awvalid, wvalid, bready, arvalid, rready} = '0;
        {awaddr, wdata, araddr} = '0;
        arstN = 1'b1;

        fd = $fopen("tests/branch_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/branch_testdata.txt for reading");
            otherErrors++;
        end else begin
            while (nVec < MaxVectors && $fgets(line, fd) > 0) begin
                if (line.getc(0) != "#" &&
                    $sscanf(line, "%s %h %h %h %h %h %h %h", vecName[nVec], vecOp[nVec],
                            vecRs[nVec], vecRt[nVec], vecPc[nVec], vecOff[nVec],
                            vecTaken[nVec], vecNext[nVec]) == 8) begin
                    nVec++;
                end
            end
            $fclose(fd);
        end
        vecLoaded = 1'b1;

        // Reset asserted just after time zero, ahead of the first clock edge
        #1;
        arstN = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        arstN = 1'b1;

        if (nVec == 0) begin
            $display("no branch vectors were found in the data file");
            otherErrors++;
        end else begin
            nTaken = 0;
            for (int i = 0; i < nVec; i++) begin
                nTaken += vecTaken[i];
            end
            readExpect("reset CTRL", `BR_REG_CTRL, '0);
            readExpect("reset RESOLVED", `BR_REG_RESOLVED, '0);
            readExpect("reset TAKEN", `BR_REG_TAKEN, '0);

            // Counting on, vectors back to back
            axiWrite(`BR_REG_CTRL, 32'h1);
            readExpect("enabled CTRL", `BR_REG_CTRL, count_t'(1));
            for (int i = 0; i < nVec; i++) begin
                issueVector(i);
            end
            idleCycles(2);
            readExpect("enabled RESOLVED", `BR_REG_RESOLVED, count_t'(nVec));
            readExpect("enabled TAKEN", `BR_REG_TAKEN, count_t'(nTaken));

            // Counting off, random gaps between issues
            axiWrite(`BR_REG_CTRL, 32'h0);
            for (int i = 0; i < nVec; i++) begin
                idleCycles($urandom_range(3, 0));
                issueVector(i);
            end
            idleCycles(2);
            readExpect("disabled RESOLVED", `BR_REG_RESOLVED, count_t'(nVec));
            readExpect("disabled TAKEN", `BR_REG_TAKEN, count_t'(nTaken));
            readExpect("disabled CTRL", `BR_REG_CTRL, '0);

            axiWrite(`BR_REG_RESOLVED, 32'h0000_5555);
            readExpect("written RESOLVED", `BR_REG_RESOLVED, count_t'(nVec));
            readExpect("unmapped read", 4'hc, '0);

            axiWrite(`BR_REG_CTRL, 32'h2);
            readExpect("cleared RESOLVED", `BR_REG_RESOLVED, '0);
            readExpect("cleared TAKEN", `BR_REG_TAKEN, '0);
        end

        reportCounts();
        if (mismatches + otherErrors + u_dut.uChk.failCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/branch_testdata.txt
# Columns are name, op, rs, rt, pc, offset, expected taken and expected nextPc
# All fields after the name are hex
beqEqual     0 00000005 00000005 00001000 0010 1 00001044
beqDiffer    0 00000005 00000006 00001000 0010 0 00001004
bneDiffer    1 00000005 00000006 00002000 fff0 1 00001fc4
bneEqualMax  1 7fffffff 7fffffff 00002000 fff0 0 00002004
bneMinZero   1 80000000 00000000 00007000 ffff 1 00007000
bltLess      2 ffffffff 00000001 00003000 0001 1 00003008
bltMinMax    2 80000000 7fffffff 00003000 0001 1 00003008
bltMaxMin    2 7fffffff 80000000 00003000 0001 0 00003004
bltEqual     2 00000003 00000003 00003000 0001 0 00003004
bgtMaxMin    3 7fffffff 80000000 00004000 0100 1 00004404
bgtLessNeg   3 fffffffe ffffffff 00004000 0100 0 00004004
bgtEqualMin  3 80000000 80000000 00004000 0100 0 00004004
blezZero     4 00000000 12345678 00005000 8000 1 fffe5004
blezMin      4 80000000 00000000 00005000 8000 1 fffe5004
blezPos      4 00000001 00000000 00005000 8000 0 00005004
bgtzMax      5 7fffffff 00000000 fffffff0 0008 1 00000014
bgtzZero     5 00000000 00000000 fffffff0 0008 0 fffffff4
bgtzNeg      5 ffffffff 00000000 fffffff0 0008 0 fffffff4
bltzNeg      6 ffffffff 00000000 fffffffc 0004 1 00000010
bltzZero     6 00000000 00000000 fffffffc 0004 0 00000000
bltzPos      6 00000001 00000000 fffffffc 0004 0 00000000
bgezZero     7 00000000 00000000 00006000 7fff 1 00026000
bgezMax      7 7fffffff 00000000 00006000 7fff 1 00026000
bgezMin      7 80000000 00000000 00006000 7fff 0 00006004

//--- build.f
+incdir+hdl
hdl/branchPkg.sv
hdl/branchComparator.sv
hdl/branchResolve.sv
hdl/branchStatsRegs.sv
hdl/branchUnitTop.sv
tests/branchUnit_chk.sv
tests/branchUnit_tb.sv
